//--- pipe_pkg.sv
package pipe_pkg;

  localparam int TAG_W = 8;  // instruction tag width
  localparam int STG_W = 6;  // stall / flush vector width

  // bit positions in the stall and flush vectors, bit 5 is spare
  localparam int STG_PC    = 0;
  localparam int STG_IFID  = 1;
  localparam int STG_IDEX  = 2;
  localparam int STG_EXMEM = 3;
  localparam int STG_MEMWB = 4;

  // instruction class, fixed codes so stimulus files can use plain numbers
  typedef enum logic [2:0] {
    KIND_ALU    = 3'd0,
    KIND_LOAD   = 3'd1,
    KIND_BRANCH = 3'd2,
    KIND_MULDIV = 3'd3,
    KIND_CSR    = 3'd4,
    KIND_ECALL  = 3'd5
  } kind_e;

  // front-end descriptor, IF_ID and ID_EX
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    kind_e            kind;
    logic [4:0]       rd;     // destination, x0 never hazards
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic             taken;  // branch outcome, resolved in execute
  } instr_t;

  // back-end descriptor, register numbers no longer needed
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    kind_e            kind;
  } ret_t;

endpackage

//--- hazard_req_if.sv
`timescale 1ns/1ns

// hazard request levels, sources to hazard_ctrl
interface hazard_req_if;

  logic if_wait;      // fetch memory not ready
  logic mem_wait;     // data memory not ready
  logic load_use;     // load in ID_EX feeds IF_ID
  logic jump;         // taken branch in execute
  logic muldiv_busy;  // mul/div still computing
  logic trap_stall;   // csr serialization cycle
  logic trap_flush;   // ecall or csr leaving EX_MEM

  modport ld_src (output load_use);
  // sources below see the waits so they know when EX_MEM / ID_EX really move
  modport md_src (input if_wait, mem_wait, output muldiv_busy);
  modport trap_src (input if_wait, mem_wait, output trap_stall, trap_flush);
  modport ctrl (
    input if_wait, mem_wait, load_use, jump, muldiv_busy, trap_stall, trap_flush
  );

endinterface

//--- hazard_ctrl.sv
`timescale 1ns/1ns

// fixed priority encoder, hazard requests to per-register stall / flush bits
// bit order {spare, MEM_WB, EX_MEM, ID_EX, IF_ID, PC}
module hazard_ctrl (
  input  logic                       rst_i,
  hazard_req_if.ctrl                 req,
  output logic [pipe_pkg::STG_W-1:0] stall_o,
  output logic [pipe_pkg::STG_W-1:0] flush_o
);

  // reset clears every stage register
  localparam logic [pipe_pkg::STG_W-1:0] rst_stall   = 6'b000000;
  localparam logic [pipe_pkg::STG_W-1:0] rst_flush   = 6'b011111;
  // memory wait freezes up to EX_MEM, bubble into MEM_WB
  localparam logic [pipe_pkg::STG_W-1:0] mem_stall   = 6'b001111;
  localparam logic [pipe_pkg::STG_W-1:0] mem_flush   = 6'b010000;
  // ecall leaves EX_MEM, everything younger dropped
  localparam logic [pipe_pkg::STG_W-1:0] ecall_stall = 6'b000000;
  localparam logic [pipe_pkg::STG_W-1:0] ecall_flush = 6'b001110;
  // csr serialization, whole pipe frozen for a cycle
  localparam logic [pipe_pkg::STG_W-1:0] csr_stall   = 6'b111111;
  localparam logic [pipe_pkg::STG_W-1:0] csr_flush   = 6'b001110;
  // taken branch in ID_EX kills IF_ID and the word being fetched
  localparam logic [pipe_pkg::STG_W-1:0] jump_stall  = 6'b000000;
  localparam logic [pipe_pkg::STG_W-1:0] jump_flush  = 6'b000110;
  // mul/div holds front end and ID_EX, bubble to EX_MEM
  localparam logic [pipe_pkg::STG_W-1:0] md_stall    = 6'b000111;
  localparam logic [pipe_pkg::STG_W-1:0] md_flush    = 6'b001000;
  // load-use holds PC and IF_ID, bubble to ID_EX
  localparam logic [pipe_pkg::STG_W-1:0] ld_stall    = 6'b000011;
  localparam logic [pipe_pkg::STG_W-1:0] ld_flush    = 6'b000100;

  logic mem_hold;  // either memory port waiting

  assign mem_hold = req.if_wait | req.mem_wait;

  // later stage wins
  always_comb begin
    if (rst_i) begin
      stall_o = rst_stall;
      flush_o = rst_flush;
    end else if (mem_hold) begin
      stall_o = mem_stall;
      flush_o = mem_flush;
    end else if (req.trap_flush) begin  // memory stage
      stall_o = ecall_stall;
      flush_o = ecall_flush;
    end else if (req.trap_stall) begin
      stall_o = csr_stall;
      flush_o = csr_flush;
    end else if (req.jump) begin  // execute stage
      stall_o = jump_stall;
      flush_o = jump_flush;
    end else if (req.muldiv_busy) begin
      stall_o = md_stall;
      flush_o = md_flush;
    end else if (req.load_use) begin  // decode stage
      stall_o = ld_stall;
      flush_o = ld_flush;
    end else begin
      stall_o = '0;  // free flow
      flush_o = '0;
    end
  end

endmodule

//--- pipe_stage_reg.sv
`timescale 1ns/1ns

// one pipeline register, flush beats stall beats load
module pipe_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     stall_i,  // hold current contents
  input  logic     flush_i,  // load a bubble
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  // valid is the only control state
  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      valid_o <= 1'b0;
    end else if (!stall_i) begin
      valid_o <= valid_i;
    end
  end

  // payload only meaningful while valid_o is high
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      data_o <= data_i;
    end
  end

endmodule

//--- load_use_detect.sv
`timescale 1ns/1ns

// load in ID_EX whose result the IF_ID instruction wants next cycle
module load_use_detect (
  input  logic             ifid_valid_i,
  input  pipe_pkg::instr_t ifid_i,
  input  logic             idex_valid_i,
  input  pipe_pkg::instr_t idex_i,
  hazard_req_if.ld_src     req
);

  logic ld_in_ex;  // valid load with a real destination
  logic src_hit;   // either source matches

  assign ld_in_ex = idex_valid_i && idex_i.kind == pipe_pkg::KIND_LOAD
                    && idex_i.rd != 5'd0;

  assign src_hit = (idex_i.rd == ifid_i.rs1) || (idex_i.rd == ifid_i.rs2);

  // one bubble is enough, data forwarded from memory stage afterwards
  assign req.load_use = ld_in_ex && ifid_valid_i && src_hit;

endmodule

//--- muldiv_seq.sv
`timescale 1ns/1ns

// multicycle mul/div timing, busy for MULDIV_CYCLES-1 cycles then release
module muldiv_seq #(
  parameter int MULDIV_CYCLES = 4  // 2 or more
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            idex_valid_i,
  input  pipe_pkg::kind_e idex_kind_i,
  hazard_req_if.md_src    req
);

  localparam int CNT_W = $clog2(MULDIV_CYCLES);

  logic             hit;    // mul/div sitting in ID_EX
  logic             armed;  // counter running or done for this instr
  logic [CNT_W-1:0] cnt;    // busy cycles still to go
  logic             held;   // ID_EX frozen by a memory wait

  assign hit  = idex_valid_i && idex_kind_i == pipe_pkg::KIND_MULDIV;
  assign held = req.if_wait | req.mem_wait;

  // first cycle busy straight away, counter not yet loaded
  assign req.muldiv_busy = hit && (!armed || cnt != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      armed <= 1'b0;
      cnt   <= '0;
    end else if (!armed) begin
      if (hit) begin
        armed <= 1'b1;
        cnt   <= CNT_W'(MULDIV_CYCLES - 2);  // first busy cycle already spent
      end
    end else if (!hit) begin
      armed <= 1'b0;  // killed by a flush while busy
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end else if (!held) begin
      armed <= 1'b0;  // leaves ID_EX this edge, next mul/div starts fresh
    end
  end

endmodule

//--- mem_trap_unit.sv
`timescale 1ns/1ns

// traps taken in the memory stage, looking at EX_MEM
// ecall and csr both drop the three younger instructions as they leave EX_MEM,
// a csr then freezes the pipe one extra cycle
module mem_trap_unit (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        exmem_valid_i,
  input  pipe_pkg::ret_t              exmem_i,
  hazard_req_if.trap_src              req,
  output logic                        trap_o,
  output logic [pipe_pkg::TAG_W-1:0]  trap_tag_o
);

  logic held;      // EX_MEM frozen by a memory wait
  logic is_ecall;
  logic is_csr;
  logic csr_hold;  // serialization cycle pending

  assign held     = req.if_wait | req.mem_wait;
  assign is_ecall = exmem_valid_i && exmem_i.kind == pipe_pkg::KIND_ECALL;
  assign is_csr   = exmem_valid_i && exmem_i.kind == pipe_pkg::KIND_CSR;

  // only when EX_MEM really advances, so one pulse per instruction
  assign req.trap_flush = (is_ecall || is_csr) && !held;
  assign req.trap_stall = csr_hold;

  assign trap_o     = is_ecall && !held;
  assign trap_tag_o = exmem_i.tag;

  always_ff @(posedge clk) begin
    if (rst) begin
      csr_hold <= 1'b0;
    end else if (is_csr && !held) begin
      csr_hold <= 1'b1;  // csr now in MEM_WB
    end else if (!held) begin
      csr_hold <= 1'b0;  // freeze took effect, a wait would have overridden it
    end
  end

endmodule

//--- pipe_ctrl_top.sv
`timescale 1ns/1ns

// five stage hazard control, descriptors only, no datapath
module pipe_ctrl_top #(
  parameter int MULDIV_CYCLES = 4
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       fetch_valid_i,
  input  pipe_pkg::instr_t           fetch_instr_i,
  output logic                       fetch_ready_o,
  input  logic                       if_wait_i,
  input  logic                       mem_wait_i,
  output logic                       retire_valid_o,
  output logic [pipe_pkg::TAG_W-1:0] retire_tag_o,
  output logic                       trap_o,
  output logic [pipe_pkg::TAG_W-1:0] trap_tag_o,
  output logic [pipe_pkg::STG_W-1:0] stall_o,
  output logic [pipe_pkg::STG_W-1:0] flush_o
);

  logic             ifid_valid;
  pipe_pkg::instr_t ifid_q;
  logic             idex_valid;
  pipe_pkg::instr_t idex_q;
  pipe_pkg::ret_t   exmem_d;      // execute result, narrowed
  logic             exmem_valid;
  pipe_pkg::ret_t   exmem_q;
  logic             memwb_valid;
  pipe_pkg::ret_t   memwb_q;

  hazard_req_if req_if ();

  assign req_if.if_wait  = if_wait_i;
  assign req_if.mem_wait = mem_wait_i;

  // branch resolves in execute
  assign req_if.jump = idex_valid && idex_q.kind == pipe_pkg::KIND_BRANCH && idex_q.taken;

  // PC register modelled by the fetch source itself
  assign fetch_ready_o = ~stall_o[pipe_pkg::STG_PC];

  // register numbers dropped past execute
  assign exmem_d = '{tag: idex_q.tag, kind: idex_q.kind};

  // MEM_WB held during csr freeze, show the instruction once when it leaves
  assign retire_valid_o = memwb_valid && !stall_o[pipe_pkg::STG_MEMWB];
  assign retire_tag_o   = memwb_q.tag;

  hazard_ctrl ctrl0 (
    .rst_i   (rst),
    .req     (req_if.ctrl),
    .stall_o (stall_o),
    .flush_o (flush_o)
  );

  pipe_stage_reg #(.payload_t(pipe_pkg::instr_t)) ifid_reg (
    .clk     (clk),
    .rst     (rst),
    .stall_i (stall_o[pipe_pkg::STG_IFID]),
    .flush_i (flush_o[pipe_pkg::STG_IFID]),
    .valid_i (fetch_valid_i),  // accepted when PC not stalled
    .data_i  (fetch_instr_i),
    .valid_o (ifid_valid),
    .data_o  (ifid_q)
  );

  pipe_stage_reg #(.payload_t(pipe_pkg::instr_t)) idex_reg (
    .clk     (clk),
    .rst     (rst),
    .stall_i (stall_o[pipe_pkg::STG_IDEX]),
    .flush_i (flush_o[pipe_pkg::STG_IDEX]),
    .valid_i (ifid_valid),
    .data_i  (ifid_q),
    .valid_o (idex_valid),
    .data_o  (idex_q)
  );

  pipe_stage_reg #(.payload_t(pipe_pkg::ret_t)) exmem_reg (
    .clk     (clk),
    .rst     (rst),
    .stall_i (stall_o[pipe_pkg::STG_EXMEM]),
    .flush_i (flush_o[pipe_pkg::STG_EXMEM]),
    .valid_i (idex_valid),
    .data_i  (exmem_d),
    .valid_o (exmem_valid),
    .data_o  (exmem_q)
  );

  pipe_stage_reg #(.payload_t(pipe_pkg::ret_t)) memwb_reg (
    .clk     (clk),
    .rst     (rst),
    .stall_i (stall_o[pipe_pkg::STG_MEMWB]),
    .flush_i (flush_o[pipe_pkg::STG_MEMWB]),
    .valid_i (exmem_valid),
    .data_i  (exmem_q),
    .valid_o (memwb_valid),
    .data_o  (memwb_q)
  );

  load_use_detect ld0 (
    .ifid_valid_i (ifid_valid),
    .ifid_i       (ifid_q),
    .idex_valid_i (idex_valid),
    .idex_i       (idex_q),
    .req          (req_if.ld_src)
  );

  muldiv_seq #(.MULDIV_CYCLES(MULDIV_CYCLES)) md0 (
    .clk          (clk),
    .rst          (rst),
    .idex_valid_i (idex_valid),
    .idex_kind_i  (idex_q.kind),
    .req          (req_if.md_src)
  );

  mem_trap_unit trap0 (
    .clk           (clk),
    .rst           (rst),
    .exmem_valid_i (exmem_valid),
    .exmem_i       (exmem_q),
    .req           (req_if.trap_src),
    .trap_o        (trap_o),
    .trap_tag_o    (trap_tag_o)
  );

endmodule

//--- pipe_checker.sv
`timescale 1ns/1ns

// watches the DUT ports, retirements and traps against the expected order
module pipe_checker (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       fetch_ready_i,
  input  logic                       retire_valid_i,
  input  logic [pipe_pkg::TAG_W-1:0] retire_tag_i,
  input  logic                       trap_i,
  input  logic [pipe_pkg::TAG_W-1:0] trap_tag_i,
  input  logic [pipe_pkg::STG_W-1:0] stall_i,
  input  logic [pipe_pkg::STG_W-1:0] flush_i,
  output int                         err_cnt_o,
  output int                         chk_cnt_o,
  output int                         ret_left_o,  // retirements still awaited
  output int                         trap_left_o
);

  logic [pipe_pkg::TAG_W-1:0] ret_q[$];   // oldest first
  logic [pipe_pkg::TAG_W-1:0] trap_q[$];  // ecall tags in program order
  int err_cnt   = 0;
  int chk_cnt   = 0;
  int ret_left  = 0;
  int trap_left = 0;

  assign err_cnt_o   = err_cnt;
  assign chk_cnt_o   = chk_cnt;
  assign ret_left_o  = ret_left;
  assign trap_left_o = trap_left;

  task automatic expect_retire(input logic [pipe_pkg::TAG_W-1:0] tag);
    ret_q.push_back(tag);
    ret_left++;
  endtask

  task automatic expect_trap(input logic [pipe_pkg::TAG_W-1:0] tag);
    trap_q.push_back(tag);
    trap_left++;
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] expv);
    chk_cnt++;
    if (got !== expv) begin
      $display("[FAIL] %s got %0h expected %0h at %0t", name, got, expv, $time);
      err_cnt++;
    end
  endtask

  // mid-cycle, all combinational outputs settled
  always @(negedge clk) begin
    if (rst) begin
      compare_value("stall_o", stall_i, 32'h00);  // nothing held
      compare_value("flush_o", flush_i, 32'h1f);  // all five registers cleared
      compare_value("retire_valid_o", retire_valid_i, 32'h0);
      compare_value("trap_o", trap_i, 32'h0);
      compare_value("fetch_ready_o", fetch_ready_i, 32'h1);
    end else begin
      if (retire_valid_i) begin
        if (ret_q.size() == 0) begin
          $display("tag %0h retired after all expected tags were seen", retire_tag_i);
          err_cnt++;
        end else begin
          compare_value("retire_tag_o", retire_tag_i, ret_q.pop_front());
          ret_left--;
        end
      end
      if (trap_i) begin
        if (trap_q.size() == 0) begin
          $display("trap with tag %0h raised but no ecall left to trap", trap_tag_i);
          err_cnt++;
        end else begin
          compare_value("trap_tag_o", trap_tag_i, trap_q.pop_front());
          trap_left--;
        end
      end
    end
  end

endmodule

//--- tb_pipe_ctrl.sv
`timescale 1ns/1ns

// file driven instruction stream into pipe_ctrl_top with pipe_checker comparing
module tb_pipe_ctrl;

  localparam int MULDIV_CYCLES = 4;
  localparam int MAX_LINES     = 64;
  localparam int DRAIN_CYCLES  = 4 + MULDIV_CYCLES;  // four stage registers plus mul/div hold

  bit                         clk;  // starts low, first edge at 50 ns
  logic                       rst;
  logic                       fetch_valid;
  pipe_pkg::instr_t           fetch_instr;
  logic                       fetch_ready;
  logic                       if_wait;
  logic                       mem_wait;
  logic                       retire_valid;
  logic [pipe_pkg::TAG_W-1:0] retire_tag;
  logic                       trap;
  logic [pipe_pkg::TAG_W-1:0] trap_tag;
  logic [pipe_pkg::STG_W-1:0] stall;
  logic [pipe_pkg::STG_W-1:0] flush;
  int                         err_cnt;
  int                         chk_cnt;
  int                         ret_left;
  int                         trap_left;

  pipe_pkg::instr_t line_instr [MAX_LINES];
  int               line_ifw   [MAX_LINES];  // if_wait cycles from first offer
  int               line_memw  [MAX_LINES];
  bit               line_exp   [MAX_LINES];  // 1 = must retire
  int               n_lines = 0;
  int               limit   = 0;  // watchdog cycles
  int               tb_errs = 0;
  int unsigned      seed    = 32'd94544;

  always #50 clk = ~clk;  // 100 ns period

  pipe_ctrl_top #(.MULDIV_CYCLES(MULDIV_CYCLES)) dut0 (
    .clk (clk), .rst (rst),
    .fetch_valid_i (fetch_valid), .fetch_instr_i (fetch_instr),
    .fetch_ready_o (fetch_ready),
    .if_wait_i (if_wait), .mem_wait_i (mem_wait),
    .retire_valid_o (retire_valid), .retire_tag_o (retire_tag),
    .trap_o (trap), .trap_tag_o (trap_tag),
    .stall_o (stall), .flush_o (flush)
  );

  pipe_checker chk0 (
    .clk (clk), .rst (rst), .fetch_ready_i (fetch_ready),
    .retire_valid_i (retire_valid), .retire_tag_i (retire_tag),
    .trap_i (trap), .trap_tag_i (trap_tag), .stall_i (stall), .flush_i (flush),
    .err_cnt_o (err_cnt), .chk_cnt_o (chk_cnt),
    .ret_left_o (ret_left), .trap_left_o (trap_left)
  );

  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // taken branch, ecall and csr drop younger instructions
  function automatic bit is_killer(input pipe_pkg::instr_t ins);
    return ins.kind == pipe_pkg::KIND_ECALL || ins.kind == pipe_pkg::KIND_CSR
           || (ins.kind == pipe_pkg::KIND_BRANCH && ins.taken);
  endfunction

  // gap only where the tag group changes and no killer needs the slots
  function automatic bit gap_allowed(input int i);
    bit ok;
    ok = i > 0 && line_instr[i].tag[7:4] != line_instr[i-1].tag[7:4];
    for (int k = i - 3; k < i; k++) begin
      if (k >= 0 && is_killer(line_instr[k])) ok = 1'b0;
    end
    return ok;
  endfunction

  task automatic load_tests();
    int fd;
    int cnt;
    int f_tag, f_kind, f_rd, f_rs1, f_rs2, f_taken, f_ifw, f_memw, f_exp;
    fd = $fopen("pipe_ctrl_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open pipe_ctrl_tests.txt");
      tb_errs++;
      return;
    end
    cnt = 9;
    while (cnt == 9 && n_lines < MAX_LINES) begin
      cnt = $fscanf(fd, " %h %d %d %d %d %d %d %d %d", f_tag, f_kind, f_rd, f_rs1,
                    f_rs2, f_taken, f_ifw, f_memw, f_exp);
      if (cnt == 9) begin
        line_instr[n_lines] = '{tag: f_tag[7:0], kind: pipe_pkg::kind_e'(f_kind[2:0]),
                                rd: f_rd[4:0], rs1: f_rs1[4:0], rs2: f_rs2[4:0],
                                taken: f_taken[0]};
        line_ifw[n_lines]  = f_ifw;
        line_memw[n_lines] = f_memw;
        line_exp[n_lines]  = f_exp[0];
        n_lines++;
      end
    end
    $fclose(fd);
    if (n_lines == 0) begin
      $display("no test lines found in pipe_ctrl_tests.txt");
      tb_errs++;
    end
  endtask

  // offer one line until fetch takes it while its waits run alongside
  task automatic offer_line(input int i);
    int gap;
    int ifw;
    int memw;
    bit accepted;
    gap = 0;
    if (gap_allowed(i)) begin
      seed = lcg_next(seed);
      gap  = int'((seed >> 16) % 3);
    end
    repeat (gap) begin
      fetch_valid <= 1'b0;
      @(posedge clk);
    end
    ifw  = line_ifw[i];
    memw = line_memw[i];
    fetch_valid <= 1'b1;
    fetch_instr <= line_instr[i];
    if_wait     <= ifw > 0;
    mem_wait    <= memw > 0;
    do begin
      @(posedge clk);
      accepted = fetch_ready;  // ready in the cycle just ended
      if (ifw > 0) ifw--;
      if (memw > 0) memw--;
      if_wait  <= ifw > 0;
      mem_wait <= memw > 0;
    end while (!accepted);
  endtask

  task automatic report_and_finish();
    int missing;
    missing = ret_left + trap_left;
    if (missing != 0) begin
      $display("%0d retirements and %0d traps never appeared", ret_left, trap_left);
    end
    $display("checks %0d  check errors %0d  testbench errors %0d  missing %0d",
             chk_cnt, err_cnt, tb_errs, missing);
    if (err_cnt == 0 && tb_errs == 0 && missing == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  initial begin : main
    int max_wait;
    rst         = 1'b1;
    fetch_valid = 1'b0;
    fetch_instr = '0;
    if_wait     = 1'b0;
    mem_wait    = 1'b0;
    max_wait    = 0;
    load_tests();
    for (int i = 0; i < n_lines; i++) begin
      if (line_exp[i]) chk0.expect_retire(line_instr[i].tag);
      if (line_exp[i] && line_instr[i].kind == pipe_pkg::KIND_ECALL) begin
        chk0.expect_trap(line_instr[i].tag);
      end
      if (line_ifw[i] + line_memw[i] > max_wait) max_wait = line_ifw[i] + line_memw[i];
    end
    limit = 10 + DRAIN_CYCLES + n_lines * (MULDIV_CYCLES + max_wait + 8);
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < n_lines; i++) offer_line(i);
    fetch_valid <= 1'b0;
    while (ret_left != 0) @(posedge clk);  // last line is youngest so it drains all
    // a stray or repeated retirement still in the pipe shows up here
    repeat (DRAIN_CYCLES) @(posedge clk);
    report_and_finish();
  end

  initial begin : watchdog
    wait (limit > 0);
    repeat (limit) @(posedge clk);
    $display("watchdog expired after %0d cycles, pipeline stopped retiring", limit);
    tb_errs++;
    report_and_finish();
  end

endmodule

//--- pipe_ctrl_tests.txt
10 0 1 0 0 0 0 0 1
11 0 2 1 0 0 0 0 1
12 0 3 2 1 0 0 0 1
20 1 5 1 0 0 0 0 1
21 0 6 5 0 0 0 0 1
22 0 7 0 6 0 0 0 1
30 2 0 1 2 1 0 0 1
31 0 8 0 0 0 0 0 0
32 0 9 0 0 0 0 0 0
33 0 10 3 7 0 0 0 1
34 2 0 1 1 0 0 0 1
40 3 11 1 2 0 0 0 1
41 0 12 11 0 0 2 0 1
42 0 13 0 0 0 0 3 1
43 3 14 12 13 0 1 1 1
50 5 0 0 0 0 0 0 1
51 0 15 0 0 0 0 0 0
52 0 16 0 0 0 0 0 0
53 0 17 0 0 0 0 0 0
54 0 18 15 0 0 0 0 1
60 4 19 0 0 0 0 0 1
61 0 20 0 0 0 0 0 0
62 0 21 0 0 0 0 0 0
63 0 22 0 0 0 0 0 0
64 0 23 19 0 0 0 0 1
65 0 24 23 0 0 0 0 1

//--- pipe_ctrl_top.f
pipe_pkg.sv
hazard_req_if.sv
hazard_ctrl.sv
pipe_stage_reg.sv
load_use_detect.sv
muldiv_seq.sv
mem_trap_unit.sv
pipe_ctrl_top.sv
pipe_checker.sv
tb_pipe_ctrl.sv

//--- Bender.yml
package:
  name: pipe_ctrl

sources:
  - files:
      - pipe_pkg.sv
      - hazard_req_if.sv
      - hazard_ctrl.sv
      - pipe_stage_reg.sv
      - load_use_detect.sv
      - muldiv_seq.sv
      - mem_trap_unit.sv
      - pipe_ctrl_top.sv
  - target: test
    files:
      - pipe_checker.sv
      - tb_pipe_ctrl.sv
